// ==== lru_tag.f ====
+incdir+tests
hw/lru_pkg.sv
hw/tag_lookup.sv
hw/lru_list.sv
hw/access_ctrl.sv
hw/lru_tag_top.sv
tests/tb_lru_tag.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

TOP=tb_lru_tag
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module "$TOP" \
    -f lru_tag.f \
    -o "$TOP"

# the log decides the result
./obj_dir/"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "NO ERRORS" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/lru_model.svh ====
`ifndef LRU_MODEL_SVH
`define LRU_MODEL_SVH

    // ****************************************
    // reference model of the tag table
    // ****************************************

    lru_pkg::index_t ref_index [lru_pkg::LIST_DEPTH];
    bit              ref_valid [lru_pkg::LIST_DEPTH];
    int              ref_order [$];                   // most recent tag first.
    int              ref_free_cnt;                    // next tag never handed out.

    function automatic void reset_model();
        for (int i = 0; i < lru_pkg::LIST_DEPTH; i++) begin
            ref_index[i] = '0;
            ref_valid[i] = 1'b0;
        end
        ref_order.delete();
        ref_free_cnt = 0;
    endfunction

    // highest numbered valid tag holding idx, or -1.
    function automatic int matching_tag(input lru_pkg::index_t idx);
        int found;
        found = -1;
        for (int i = 0; i < lru_pkg::LIST_DEPTH; i++) begin
            if (ref_valid[i] && (ref_index[i] == idx)) begin
                found = i;
            end
        end
        return found;
    endfunction

    // first index at or above start that no valid tag holds.
    function automatic lru_pkg::index_t unused_index(input int start);
        lru_pkg::index_t cand;
        for (int k = 0; k < (1 << lru_pkg::INDEX_WIDTH); k++) begin
            cand = lru_pkg::index_t'(start + k);
            if (matching_tag(cand) < 0) begin
                return cand;
            end
        end
        return lru_pkg::index_t'(start);
    endfunction

    function automatic void move_to_front(input int t);
        for (int i = 0; i < ref_order.size(); i++) begin
            if (ref_order[i] == t) begin
                ref_order.delete(i);
                break;
            end
        end
        ref_order.push_front(t);
    endfunction

    // predicts the response of one request and updates the model with it.
    function automatic void apply_request(input lru_pkg::acc_cmd_t cmd,
                                          input lru_pkg::index_t idx,
                                          output lru_pkg::resp_status_t status,
                                          output lru_pkg::tag_t tag);
        int t;
        t      = matching_tag(idx);
        status = lru_pkg::ST_BAD_CMD;
        tag    = '0;
        case (cmd)
            lru_pkg::CMD_LOOKUP, lru_pkg::CMD_TOUCH: begin
                if (t >= 0) begin
                    move_to_front(t);
                    status = lru_pkg::ST_HIT;
                    tag    = lru_pkg::tag_t'(t);
                end else begin
                    status = lru_pkg::ST_MISS;
                end
            end
            lru_pkg::CMD_ALLOC: begin
                if (ref_free_cnt < lru_pkg::LIST_DEPTH) begin
                    t = ref_free_cnt;
                    ref_free_cnt++;
                    status = lru_pkg::ST_ALLOC_FREE;
                end else begin
                    t      = ref_order[$];            // least recent tag is reused.
                    status = lru_pkg::ST_ALLOC_EVICT;
                end
                move_to_front(t);
                ref_index[t] = idx;
                ref_valid[t] = 1'b1;
                tag          = lru_pkg::tag_t'(t);
            end
            default: begin
                status = lru_pkg::ST_BAD_CMD;
            end
        endcase
    endfunction

`endif

// ==== tests/tb_lru_tag.sv ====
`timescale 1ns/1ps

module tb_lru_tag;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int DIRECTED_REQS = 40;                // directed requests and idle cycles.
    localparam int RANDOM_REQS   = 200;
    localparam int MARGIN_CYCLES = 50;
    localparam int TIMEOUT_NS    =
        (RESET_CYCLES + DIRECTED_REQS + RANDOM_REQS + MARGIN_CYCLES) * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic                  acc_req;
    lru_pkg::acc_cmd_t     acc_cmd;
    lru_pkg::index_t       acc_index;
    logic                  resp_valid;
    lru_pkg::resp_status_t resp_status;
    lru_pkg::tag_t         resp_tag;

    // expected answer to the request sampled at the last rising edge.
    logic                  exp_valid;
    lru_pkg::resp_status_t exp_status;
    lru_pkg::tag_t         exp_tag;
    integer                seed;

    `include "lru_model.svh"

    lru_tag_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_req     (acc_req),
        .acc_cmd     (acc_cmd),
        .acc_index   (acc_index),
        .resp_valid  (resp_valid),
        .resp_status (resp_status),
        .resp_tag    (resp_tag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns without finishing the tests", TIMEOUT_NS);
        stop_on_failure();
    end

    // ****************************************
    // compare tasks
    // ****************************************

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s expected %h got %h", name, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_status(input string name, input lru_pkg::resp_status_t got,
                                input lru_pkg::resp_status_t exp);
        if (got !== exp) begin
            $display("error %s expected %h got %h", name, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_tag(input string name, input lru_pkg::tag_t got,
                             input lru_pkg::tag_t exp);
        if (got !== exp) begin
            $display("error %s expected %h got %h", name, exp, got);
            stop_on_failure();
        end
    endtask

    // drives one cycle and checks the answer to the previous cycle's request.
    task automatic send_request(input logic req, input lru_pkg::acc_cmd_t cmd,
                                input lru_pkg::index_t idx);
        lru_pkg::resp_status_t st;
        lru_pkg::tag_t         tg;
        @(posedge clk);
        acc_req   <= req;
        acc_cmd   <= cmd;
        acc_index <= idx;
        @(negedge clk);
        check_valid("resp_valid", resp_valid, exp_valid);
        if (exp_valid) begin
            check_status("resp_status", resp_status, exp_status);
            check_tag("resp_tag", resp_tag, exp_tag);
        end
        exp_valid = req;
        if (req) begin
            apply_request(cmd, idx, st, tg);
            exp_status = st;
            exp_tag    = tg;
        end
    endtask

    task automatic idle_cycle();
        send_request(1'b0, lru_pkg::CMD_LOOKUP, '0);
    endtask

    // ****************************************
    // directed tests
    // ****************************************

    task automatic fill_from_free();
        for (int i = 0; i < lru_pkg::LIST_DEPTH; i++) begin
            send_request(1'b1, lru_pkg::CMD_ALLOC, lru_pkg::index_t'(i + 1));
        end
        idle_cycle();
    endtask

    task automatic evict_least_recent();
        lru_pkg::index_t old_idx;
        lru_pkg::index_t new_idx;
        old_idx = ref_index[0];                       // tag 0 is the tail after the fill.
        new_idx = unused_index(9);
        send_request(1'b1, lru_pkg::CMD_ALLOC, new_idx);
        idle_cycle();
        send_request(1'b1, lru_pkg::CMD_LOOKUP, old_idx);
        send_request(1'b1, lru_pkg::CMD_TOUCH, new_idx);
        idle_cycle();
    endtask

    task automatic lookup_hits_misses();
        for (int t = 0; t < lru_pkg::LIST_DEPTH; t++) begin
            send_request(1'b1, (t % 2 == 0) ? lru_pkg::CMD_LOOKUP : lru_pkg::CMD_TOUCH,
                         ref_index[t]);
        end
        send_request(1'b1, lru_pkg::CMD_LOOKUP, unused_index(0));
        idle_cycle();
        idle_cycle();
    endtask

    task automatic recency_order();
        int head_tag;
        int tail_tag;
        for (int round = 0; round < 3; round++) begin
            head_tag = ref_order[0];
            send_request(1'b1, lru_pkg::CMD_TOUCH, ref_index[head_tag]);
            tail_tag = ref_order[$];
            send_request(1'b1, lru_pkg::CMD_LOOKUP, ref_index[tail_tag]);
            tail_tag = ref_order[$];
            send_request(1'b1, lru_pkg::CMD_LOOKUP, ref_index[tail_tag]);
            send_request(1'b1, lru_pkg::CMD_ALLOC, unused_index(round * 5));
        end
        idle_cycle();
    endtask

    task automatic reserved_command();
        send_request(1'b1, lru_pkg::CMD_RSVD, ref_index[0]);
        send_request(1'b1, lru_pkg::CMD_RSVD, unused_index(3));
        for (int t = 0; t < lru_pkg::LIST_DEPTH; t++) begin
            send_request(1'b1, lru_pkg::CMD_LOOKUP, ref_index[t]);
        end
        idle_cycle();
    endtask

    task automatic random_traffic();
        int                r;
        lru_pkg::acc_cmd_t cmd;
        lru_pkg::index_t   idx;
        for (int n = 0; n < RANDOM_REQS; n++) begin
            r   = $random(seed);
            cmd = lru_pkg::acc_cmd_t'(r[1:0]);
            idx = lru_pkg::index_t'(r[7:4]);
            if (cmd == lru_pkg::CMD_ALLOC) begin
                idx = unused_index(int'(idx));        // never store an index twice.
            end else if (r[8]) begin
                idx = ref_index[r[10:9]];             // favour hits.
            end
            send_request(1'b1, cmd, idx);
        end
        idle_cycle();
    endtask

    initial begin
        seed       = 9987;
        rst_n      = 1'b0;
        acc_req    = 1'b0;
        acc_cmd    = lru_pkg::CMD_LOOKUP;
        acc_index  = '0;
        exp_valid  = 1'b0;
        exp_status = lru_pkg::ST_NONE;
        exp_tag    = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_valid("resp_valid", resp_valid, 1'b0);
        check_status("resp_status", resp_status, lru_pkg::ST_NONE);
        fill_from_free();
        evict_least_recent();
        lookup_hits_misses();
        recency_order();
        reserved_command();
        random_traffic();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== hw/lru_tag_top.sv ====
`timescale 1ns/1ps

module lru_tag_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  acc_req,
    input  lru_pkg::acc_cmd_t     acc_cmd,
    input  lru_pkg::index_t       acc_index,
    output logic                  resp_valid,
    output lru_pkg::resp_status_t resp_status,
    output lru_pkg::tag_t         resp_tag
);

    // lookup results.
    logic          hit;
    lru_pkg::tag_t hit_tag;

    // list state seen by the decoder.
    logic          free_avail;
    lru_pkg::tag_t free_tag;
    lru_pkg::tag_t lru_tail;

    // list operation strobes.
    logic          touch;
    logic          insert;
    lru_pkg::tag_t op_tag;

    // tag table write.
    logic          wr_en;
    lru_pkg::tag_t wr_tag;

    tag_lookup u_tag_lookup (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_index  (acc_index),
        .wr_en      (wr_en),
        .wr_tag     (wr_tag),
        .hit        (hit),
        .hit_tag    (hit_tag)
    );

    lru_list u_lru_list (
        .clk        (clk),
        .rst_n      (rst_n),
        .touch      (touch),
        .insert     (insert),
        .op_tag     (op_tag),
        .free_avail (free_avail),
        .free_tag   (free_tag),
        .lru_tail   (lru_tail)
    );

    access_ctrl u_access_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_req     (acc_req),
        .acc_cmd     (acc_cmd),
        .hit         (hit),
        .hit_tag     (hit_tag),
        .free_avail  (free_avail),
        .free_tag    (free_tag),
        .lru_tail    (lru_tail),
        .touch       (touch),
        .insert      (insert),
        .op_tag      (op_tag),
        .wr_en       (wr_en),
        .wr_tag      (wr_tag),
        .resp_valid  (resp_valid),
        .resp_status (resp_status),
        .resp_tag    (resp_tag)
    );

endmodule

// ==== hw/access_ctrl.sv ====
`timescale 1ns/1ps

module access_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  acc_req,
    input  lru_pkg::acc_cmd_t     acc_cmd,
    input  logic                  hit,
    input  lru_pkg::tag_t         hit_tag,
    input  logic                  free_avail,
    input  lru_pkg::tag_t         free_tag,
    input  lru_pkg::tag_t         lru_tail,
    output logic                  touch,
    output logic                  insert,
    output lru_pkg::tag_t         op_tag,
    output logic                  wr_en,
    output lru_pkg::tag_t         wr_tag,
    output logic                  resp_valid,
    output lru_pkg::resp_status_t resp_status,
    output lru_pkg::tag_t         resp_tag
);

    lru_pkg::resp_status_t status_d;
    lru_pkg::tag_t         tag_d;

    // ****************************************
    // command decode
    // ****************************************

    always_comb begin
        touch    = 1'b0;
        insert   = 1'b0;
        op_tag   = '0;
        wr_en    = 1'b0;
        wr_tag   = '0;
        status_d = lru_pkg::ST_NONE;
        tag_d    = '0;
        if (acc_req) begin
            case (acc_cmd)
                lru_pkg::CMD_LOOKUP, lru_pkg::CMD_TOUCH: begin
                    if (hit) begin
                        touch    = 1'b1;       // a hit becomes most recent.
                        op_tag   = hit_tag;
                        status_d = lru_pkg::ST_HIT;
                        tag_d    = hit_tag;
                    end else begin
                        status_d = lru_pkg::ST_MISS;
                    end
                end
                lru_pkg::CMD_ALLOC: begin
                    wr_en = 1'b1;
                    if (free_avail) begin
                        insert   = 1'b1;
                        wr_tag   = free_tag;
                        status_d = lru_pkg::ST_ALLOC_FREE;
                        tag_d    = free_tag;
                    end else begin
                        touch    = 1'b1;       // evicted tag is reused as most recent.
                        op_tag   = lru_tail;
                        wr_tag   = lru_tail;
                        status_d = lru_pkg::ST_ALLOC_EVICT;
                        tag_d    = lru_tail;
                    end
                end
                default: begin
                    status_d = lru_pkg::ST_BAD_CMD;
                end
            endcase
        end
    end

    // ****************************************
    // response registers
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid  <= 1'b0;
            resp_status <= lru_pkg::ST_NONE;
            resp_tag    <= '0;
        end else begin
            resp_valid <= acc_req;
            if (acc_req) begin
                resp_status <= status_d;
                resp_tag    <= tag_d;
            end
        end
    end

endmodule

// ==== hw/lru_list.sv ====
`timescale 1ns/1ps

module lru_list (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          touch,
    input  logic          insert,
    input  lru_pkg::tag_t op_tag,
    output logic          free_avail,
    output lru_pkg::tag_t free_tag,
    output lru_pkg::tag_t lru_tail
);

    lru_pkg::tag_t   pre_q [lru_pkg::LIST_DEPTH];   // neighbour towards the head.
    lru_pkg::tag_t   nxt_q [lru_pkg::LIST_DEPTH];   // neighbour towards the tail.
    lru_pkg::tag_t   head_q;
    lru_pkg::tag_t   tail_q;
    lru_pkg::count_t length_q;
    lru_pkg::count_t free_cnt_q;

    logic            list_empty;
    logic            op_is_head;
    logic            op_is_tail;
    logic            do_move;
    lru_pkg::tag_t   op_pre;
    lru_pkg::tag_t   op_nxt;

    assign list_empty = (length_q == '0);
    assign op_is_head = (op_tag == head_q);
    assign op_is_tail = (op_tag == tail_q);
    assign op_pre     = pre_q[op_tag];
    assign op_nxt     = nxt_q[op_tag];

    // a touch of the head leaves the order as it is.
    assign do_move    = touch && !insert && !op_is_head;

    // ****************************************
    // recency list
    // ****************************************

    // neighbour pointers around an inserted or moved tag.
    always_ff @(posedge clk) begin
        if (insert) begin
            if (!list_empty) begin
                nxt_q[free_tag] <= head_q;
                pre_q[head_q]   <= free_tag;
            end
        end else if (do_move) begin
            nxt_q[op_pre] <= op_nxt;           // close the gap behind op_tag.
            if (!op_is_tail) begin
                pre_q[op_nxt] <= op_pre;
            end
            nxt_q[op_tag] <= head_q;           // relink in front of the head.
            pre_q[head_q] <= op_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q   <= '0;
            tail_q   <= '0;
            length_q <= '0;
        end else if (insert) begin
            head_q   <= free_tag;
            length_q <= length_q + 1'b1;
            if (list_empty) begin
                tail_q <= free_tag;            // first entry is also the tail.
            end
        end else if (do_move) begin
            head_q <= op_tag;
            if (op_is_tail) begin
                tail_q <= op_pre;              // predecessor becomes least recent.
            end
        end
    end

    assign lru_tail = tail_q;

    // ****************************************
    // free tag counter
    // ****************************************

    // tags are never released, so they are handed out in ascending order.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_cnt_q <= '0;
        end else if (insert) begin
            free_cnt_q <= free_cnt_q + 1'b1;
        end
    end

    assign free_avail = (free_cnt_q != lru_pkg::count_t'(lru_pkg::LIST_DEPTH));
    assign free_tag   = free_cnt_q[lru_pkg::TAG_WIDTH-1:0];

endmodule

// ==== hw/tag_lookup.sv ====
`timescale 1ns/1ps

module tag_lookup (
    input  logic            clk,
    input  logic            rst_n,
    input  lru_pkg::index_t acc_index,
    input  logic            wr_en,
    input  lru_pkg::tag_t   wr_tag,
    output logic            hit,
    output lru_pkg::tag_t   hit_tag
);

    lru_pkg::index_t                  index_q [lru_pkg::LIST_DEPTH];
    logic [lru_pkg::LIST_DEPTH-1:0]   valid_q;
    logic [lru_pkg::LIST_DEPTH-1:0]   match;

    // ****************************************
    // per tag storage
    // ****************************************

    always_ff @(posedge clk) begin
        if (wr_en) begin
            index_q[wr_tag] <= acc_index;      // new index for the allocated tag.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_tag] <= 1'b1;           // stays set until reset.
        end
    end

    // ****************************************
    // parallel compare
    // ****************************************

    always_comb begin
        for (int i = 0; i < lru_pkg::LIST_DEPTH; i++) begin
            match[i] = valid_q[i] && (index_q[i] == acc_index);
        end
    end

    // later entries override, so the highest matching tag wins.
    always_comb begin
        hit_tag = '0;
        for (int i = 0; i < lru_pkg::LIST_DEPTH; i++) begin
            if (match[i]) begin
                hit_tag = lru_pkg::tag_t'(i);
            end
        end
    end

    assign hit = |match;

endmodule

// ==== hw/lru_pkg.sv ====
package lru_pkg;

    // ****************************************
    // table geometry
    // ****************************************

    localparam int LIST_DEPTH  = 4;                   // number of tags.
    localparam int INDEX_WIDTH = 4;                   // width of a stored index.
    localparam int TAG_WIDTH   = $clog2(LIST_DEPTH);  // width of a tag number.

    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH:0]     count_t;          // one extra bit to reach LIST_DEPTH.

    // ****************************************
    // request and response encodings
    // ****************************************

    typedef enum logic [1:0] {
        CMD_LOOKUP = 2'b00,
        CMD_TOUCH  = 2'b01,                           // same behaviour as lookup.
        CMD_ALLOC  = 2'b10,
        CMD_RSVD   = 2'b11
    } acc_cmd_t;

    typedef enum logic [2:0] {
        ST_NONE        = 3'b000,                      // nothing answered yet.
        ST_HIT         = 3'b001,
        ST_MISS        = 3'b010,
        ST_ALLOC_FREE  = 3'b011,
        ST_ALLOC_EVICT = 3'b100,
        ST_BAD_CMD     = 3'b101
    } resp_status_t;

endpackage
